// ==== filelist.f ====
stream_pkg.sv
stream_two_fifo.sv
stream_pump_in.sv
stream_mem_slave.sv
stream_mem_top.sv
stream_mem_chk.sv
stream_mem_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build the stream memory testbench with Verilator, run it, and check the log

cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f filelist.f --top-module stream_mem_tb -o stream_mem_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/stream_mem_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^Result: PASSED$" "$log"; then
  exit 0
fi
echo "pass message not found in $log"
exit 1

// ==== stream_mem_chk.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// response handshake checker, bound into the memory slave
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module stream_mem_chk
  ( input logic                                 clk_i
  , input logic                                 reset_i
  , input stream_pkg::msg_header_s              resp_header_i
  , input logic [stream_pkg::data_width_lp-1:0] resp_data_i
  , input logic                                 resp_v_i
  , input logic                                 resp_last_i
  , input logic                                 resp_ready_and_i
  , input logic                                 proto_err_i
  );

  // a stalled beat must be presented again unchanged in the next cycle
  assert property (@(posedge clk_i) disable iff (reset_i)
    (resp_v_i && !resp_ready_and_i) |=>
      (resp_v_i && $stable(resp_header_i) && $stable(resp_data_i) && $stable(resp_last_i)))
    else $error("response beat changed or vanished while the master held ready low");

  // last only marks a beat that is really there
  assert property (@(posedge clk_i) disable iff (reset_i) resp_last_i |-> resp_v_i)
    else $error("resp_last_o raised without resp_v_o");

  // the slave saw a message start inside an open one
  assert property (@(posedge clk_i) disable iff (reset_i) !proto_err_i)
    else $error("memory slave flagged a protocol error");

endmodule

bind stream_mem_slave stream_mem_chk u_chk
  ( .clk_i            (clk_i)
  , .reset_i          (reset_i)
  , .resp_header_i    (resp_header_o)
  , .resp_data_i      (resp_data_o)
  , .resp_v_i         (resp_v_o)
  , .resp_last_i      (resp_last_o)
  , .resp_ready_and_i (resp_ready_and_i)
  , .proto_err_i      (proto_err_r)
  );

`default_nettype wire

// ==== stream_mem_slave.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// register memory slave: performs word reads and writes and
// forms read data beats and the write acknowledge
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module stream_mem_slave
  ( input  logic                                 clk_i
  , input  logic                                 reset_i
  // operations from the pump
  , input  stream_pkg::msg_header_s              fsm_header_i
  , input  logic [stream_pkg::addr_width_lp-1:0] fsm_addr_i
  , input  logic [stream_pkg::data_width_lp-1:0] fsm_data_i
  , input  logic                                 fsm_v_i
  , input  logic                                 fsm_new_i
  , input  logic                                 fsm_done_i
  , output logic                                 fsm_yumi_o
  // response stream
  , output stream_pkg::msg_header_s              resp_header_o
  , output logic [stream_pkg::data_width_lp-1:0] resp_data_o
  , output logic                                 resp_v_o
  , output logic                                 resp_last_o
  , input  logic                                 resp_ready_and_i
  );

  logic [stream_pkg::data_width_lp-1:0] mem_r [stream_pkg::mem_words_lp];
  logic [stream_pkg::mem_index_width_lp-1:0] word_idx;
  logic [stream_pkg::cnt_width_lp-1:0] mask, next_cnt, crit_cnt;
  logic is_wr, last_word;
  logic open_r, proto_err_r;

  assign word_idx = fsm_addr_i[stream_pkg::word_offset_width_lp+:stream_pkg::mem_index_width_lp];
  assign is_wr = (fsm_header_i.msg_type == stream_pkg::e_wr);

  // the final word is the one just before the critical word in wrap order
  always_comb
  begin
    mask      = stream_pkg::word_mask(fsm_header_i.size);
    next_cnt  = fsm_addr_i[stream_pkg::word_offset_width_lp+:stream_pkg::cnt_width_lp] + 1'b1;
    crit_cnt  = fsm_header_i.addr[stream_pkg::word_offset_width_lp+:stream_pkg::cnt_width_lp];
    last_word = ((next_cnt & mask) == (crit_cnt & mask));
  end

  always_comb
  begin
    fsm_yumi_o    = 1'b0;
    resp_v_o      = 1'b0;
    resp_last_o   = 1'b0;
    resp_header_o = fsm_header_i;
    resp_data_o   = mem_r[word_idx];

    if (fsm_v_i)
    begin
      if (is_wr & ~last_word)
        // middle write beats go straight into memory with no response
        fsm_yumi_o = 1'b1;
      else if (is_wr)
      begin
        // last write word is consumed together with the acknowledge beat
        resp_v_o               = 1'b1;
        resp_last_o            = 1'b1;
        resp_header_o.msg_type = stream_pkg::e_ack;
        resp_data_o            = '0;
        fsm_yumi_o             = resp_ready_and_i;
      end
      else if (fsm_header_i.msg_type == stream_pkg::e_rd)
      begin
        resp_v_o           = 1'b1;
        resp_last_o        = last_word;
        resp_header_o.addr = fsm_addr_i;
        fsm_yumi_o         = resp_ready_and_i;
      end
      else
        // other types have no meaning for a memory and are dropped
        fsm_yumi_o = 1'b1;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      mem_r <= '{default: '0};
    else if (fsm_yumi_o & is_wr)
      mem_r[word_idx] <= fsm_data_i;
  end

  // open_r tracks a message between its first consumed word and done
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      open_r      <= 1'b0;
      proto_err_r <= 1'b0;
    end
    else
    begin
      if (fsm_done_i)
        open_r <= 1'b0;
      else if (fsm_new_i & fsm_yumi_o)
        open_r <= 1'b1;
      // a second message start inside an open one is sticky
      if (fsm_v_i & fsm_new_i & open_r)
        proto_err_r <= 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== stream_mem_tb.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for the stream memory endpoint: directed and
// random messages checked against a reference memory
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module stream_mem_tb;

  localparam int reset_cycles_lp = 8;
  localparam int random_msgs_lp = 60;
  // seven directed messages come before the random ones
  localparam int num_msgs_lp = 7 + random_msgs_lp;
  localparam int watchdog_cycles_lp = num_msgs_lp * 4 * 20;

  logic clk_i, reset_i;
  stream_pkg::msg_header_s in_header_i, resp_header_o;
  logic [63:0] in_data_i, resp_data_o;
  logic in_v_i, in_last_i, in_ready_and_o;
  logic resp_v_o, resp_last_o, resp_ready_and_i;

  logic [63:0] ref_mem [32];
  stream_pkg::stream_beat_s exp_q [$];
  string name_q [$];
  stream_pkg::stream_beat_s got_exp;
  string got_name;
  logic [31:0] stim_state, ready_state;
  int err_mismatch, err_other;

  stream_mem_top i_dut
    ( .clk_i            (clk_i)
    , .reset_i          (reset_i)
    , .in_header_i      (in_header_i)
    , .in_data_i        (in_data_i)
    , .in_v_i           (in_v_i)
    , .in_last_i        (in_last_i)
    , .in_ready_and_o   (in_ready_and_o)
    , .resp_header_o    (resp_header_o)
    , .resp_data_o      (resp_data_o)
    , .resp_v_o         (resp_v_o)
    , .resp_last_o      (resp_last_o)
    , .resp_ready_and_i (resp_ready_and_i)
    );

  function automatic logic [31:0] lcg_next(logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [31:0] stim_rand();
    stim_state = lcg_next(stim_state);
    return stim_state;
  endfunction

  // k-th word address of a message: aligned N-word group, starting at the critical word
  function automatic logic [7:0] wrap_addr(stream_pkg::msg_header_s hdr, int k);
    int n, first, base;
    logic [1:0] word;
    n = (1 << int'(hdr.size)) / 8;
    first = int'(hdr.addr[4:3]);
    base = first - (first % n);
    word = 2'(base + (first - base + k) % n);
    return {hdr.addr[7:5], word, hdr.addr[2:0]};
  endfunction

  function automatic stream_pkg::msg_header_s make_header
    (stream_pkg::msg_type_e t, stream_pkg::size_e s, logic [7:0] a);
    stream_pkg::msg_header_s hdr;
    hdr.msg_type = t;
    hdr.size = s;
    hdr.addr = a;
    return hdr;
  endfunction

  function automatic stream_pkg::msg_header_s random_header();
    logic [31:0] r, ra;
    stream_pkg::size_e s;
    stream_pkg::msg_type_e t;
    r = stim_rand();
    ra = stim_rand();
    case (r[31:16] % 16'd3)
      16'd0: s = stream_pkg::e_size_8;
      16'd1: s = stream_pkg::e_size_16;
      default: s = stream_pkg::e_size_32;
    endcase
    if (r[15])
      t = stream_pkg::e_wr;
    else
      t = stream_pkg::e_rd;
    return make_header(t, s, ra[31:24]);
  endfunction

  // one beat with a random gap in front, held until the pump takes it
  task automatic send_beat(stream_pkg::msg_header_s hdr, logic [63:0] data, logic last);
    logic [31:0] r;
    r = stim_rand();
    while (r[31:30] == 2'b00)
    begin
      in_v_i = 1'b0;
      @(negedge clk_i);
      r = stim_rand();
    end
    in_v_i = 1'b1;
    in_header_i = hdr;
    in_data_i = data;
    in_last_i = last;
    @(posedge clk_i);
    while (!in_ready_and_o)
      @(posedge clk_i);
    @(negedge clk_i);
    in_v_i = 1'b0;
  endtask

  // expected beats are queued before the message goes out, in message order
  task automatic post_message(string name, stream_pkg::msg_header_s hdr);
    int n;
    logic [7:0] a;
    logic [63:0] d;
    stream_pkg::stream_beat_s exp_beat;
    n = (1 << int'(hdr.size)) / 8;
    if (hdr.msg_type == stream_pkg::e_wr)
    begin
      exp_beat.last = 1'b1;
      exp_beat.header = hdr;
      exp_beat.header.msg_type = stream_pkg::e_ack;
      exp_beat.data = '0;
      exp_q.push_back(exp_beat);
      name_q.push_back(name);
      for (int k = 0; k < n; k++)
      begin
        d = {stim_rand(), stim_rand()};
        a = wrap_addr(hdr, k);
        ref_mem[a[7:3]] = d;
        send_beat(hdr, d, k == n - 1);
      end
    end
    else
    begin
      for (int k = 0; k < n; k++)
      begin
        a = wrap_addr(hdr, k);
        exp_beat.last = (k == n - 1);
        exp_beat.header = hdr;
        exp_beat.header.addr = a;
        exp_beat.data = ref_mem[a[7:3]];
        exp_q.push_back(exp_beat);
        name_q.push_back(name);
      end
      send_beat(hdr, '0, 1'b1);
    end
  endtask

  initial
  begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  // the master drops ready about a third of the time
  initial
  begin
    ready_state = ~32'd32278;
    forever
    begin
      @(negedge clk_i);
      ready_state = lcg_next(ready_state);
      resp_ready_and_i = (ready_state[31:16] % 16'd3) != 16'd0;
    end
  end

  // every accepted response beat is compared with the head of the expected queue
  always @(posedge clk_i)
  begin
    if (!reset_i && resp_v_o && resp_ready_and_i)
    begin
      assert (exp_q.size() > 0)
      else
      begin
        err_other++;
        $display("response beat arrived with no beat expected at %0t", $time);
      end
      if (exp_q.size() > 0)
      begin
        got_exp = exp_q.pop_front();
        got_name = name_q.pop_front();
        assert (resp_header_o == got_exp.header)
        else
        begin
          err_mismatch++;
          $display("mismatch %s header expected %h actual %h", got_name, got_exp.header,
                   resp_header_o);
        end
        assert (resp_data_o == got_exp.data)
        else
        begin
          err_mismatch++;
          $display("mismatch %s data expected %h actual %h", got_name, got_exp.data,
                   resp_data_o);
        end
        assert (resp_last_o == got_exp.last)
        else
        begin
          err_mismatch++;
          $display("mismatch %s last expected %b actual %b", got_name, got_exp.last,
                   resp_last_o);
        end
      end
    end
  end

  initial
  begin
    repeat (reset_cycles_lp + watchdog_cycles_lp) @(posedge clk_i);
    $display("timeout: %0d response beats still missing", exp_q.size());
    $display("errors: %0d mismatch, %0d other", err_mismatch, err_other);
    $display("Result: FAILED");
    $finish;
  end

  initial
  begin
    reset_i = 1'b1;
    in_header_i = '0;
    in_data_i = '0;
    in_v_i = 1'b0;
    in_last_i = 1'b0;
    resp_ready_and_i = 1'b1;
    stim_state = 32'd32278;
    err_mismatch = 0;
    err_other = 0;
    foreach (ref_mem[w])
      ref_mem[w] = '0;
    repeat (reset_cycles_lp) @(negedge clk_i);
    reset_i = 1'b0;

    // an idle endpoint takes beats and sends nothing
    repeat (4)
    begin
      @(posedge clk_i);
      assert (in_ready_and_o === 1'b1)
      else
      begin
        err_other++;
        $display("in_ready_and_o is not high after reset");
      end
      assert (resp_v_o === 1'b0)
      else
      begin
        err_other++;
        $display("resp_v_o is high before any message was sent");
      end
    end
    @(negedge clk_i);

    post_message("wr8_rd8", make_header(stream_pkg::e_wr, stream_pkg::e_size_8, 8'h48));
    post_message("wr8_rd8", make_header(stream_pkg::e_rd, stream_pkg::e_size_8, 8'h48));
    // writes land at words 2,3,0,1 and the read returns 1,2,3,0
    post_message("wrap32", make_header(stream_pkg::e_wr, stream_pkg::e_size_32, 8'h90));
    post_message("wrap32", make_header(stream_pkg::e_rd, stream_pkg::e_size_32, 8'h88));
    // the odd-word pair wraps to word 0 and words 2 and 3 stay zero
    post_message("pair16", make_header(stream_pkg::e_wr, stream_pkg::e_size_16, 8'ha8));
    post_message("pair16", make_header(stream_pkg::e_rd, stream_pkg::e_size_16, 8'ha8));
    post_message("pair16", make_header(stream_pkg::e_rd, stream_pkg::e_size_32, 8'ha0));
    for (int m = 0; m < random_msgs_lp; m++)
      post_message("random", random_header());

    while (exp_q.size() != 0)
      @(posedge clk_i);
    // a few idle cycles catch any duplicated beat
    repeat (10) @(posedge clk_i);

    $display("errors: %0d mismatch, %0d other", err_mismatch, err_other);
    if (err_mismatch + err_other == 0)
      $display("Result: PASSED");
    else
      $display("Result: FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== stream_mem_top.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// stream memory endpoint, pump feeding the memory slave
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module stream_mem_top
  ( input  logic                                 clk_i
  , input  logic                                 reset_i
  // inbound stream from the bus master
  , input  stream_pkg::msg_header_s              in_header_i
  , input  logic [stream_pkg::data_width_lp-1:0] in_data_i
  , input  logic                                 in_v_i
  , input  logic                                 in_last_i
  , output logic                                 in_ready_and_o
  // response stream back to the master
  , output stream_pkg::msg_header_s              resp_header_o
  , output logic [stream_pkg::data_width_lp-1:0] resp_data_o
  , output logic                                 resp_v_o
  , output logic                                 resp_last_o
  , input  logic                                 resp_ready_and_i
  );

  stream_pkg::msg_header_s fsm_header;
  logic [stream_pkg::addr_width_lp-1:0] fsm_addr;
  logic [stream_pkg::data_width_lp-1:0] fsm_data;
  logic fsm_v, fsm_yumi, fsm_new, fsm_done;

  stream_pump_in u_pump
    ( .clk_i          (clk_i)
    , .reset_i        (reset_i)
    , .in_header_i    (in_header_i)
    , .in_data_i      (in_data_i)
    , .in_v_i         (in_v_i)
    , .in_last_i      (in_last_i)
    , .in_ready_and_o (in_ready_and_o)
    , .fsm_header_o   (fsm_header)
    , .fsm_addr_o     (fsm_addr)
    , .fsm_data_o     (fsm_data)
    , .fsm_v_o        (fsm_v)
    , .fsm_yumi_i     (fsm_yumi)
    , .fsm_new_o      (fsm_new)
    , .fsm_done_o     (fsm_done)
    );

  stream_mem_slave u_slave
    ( .clk_i            (clk_i)
    , .reset_i          (reset_i)
    , .fsm_header_i     (fsm_header)
    , .fsm_addr_i       (fsm_addr)
    , .fsm_data_i       (fsm_data)
    , .fsm_v_i          (fsm_v)
    , .fsm_new_i        (fsm_new)
    , .fsm_done_i       (fsm_done)
    , .fsm_yumi_o       (fsm_yumi)
    , .resp_header_o    (resp_header_o)
    , .resp_data_o      (resp_data_o)
    , .resp_v_o         (resp_v_o)
    , .resp_last_o      (resp_last_o)
    , .resp_ready_and_i (resp_ready_and_i)
    );

endmodule

`default_nettype wire

// ==== stream_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// stream memory endpoint package: widths, encodings, masks
// and the header and beat structs shared by every block
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package stream_pkg;

  // one stream word is a 64-bit dword
  localparam int data_width_lp = 64;
  // 256 byte address space
  localparam int addr_width_lp = 8;
  localparam int block_bytes_lp = 32;
  localparam int word_offset_width_lp = $clog2(data_width_lp / 8);
  localparam int stream_words_lp = block_bytes_lp / (data_width_lp / 8);
  localparam int cnt_width_lp = $clog2(stream_words_lp);
  localparam int block_offset_width_lp = $clog2(block_bytes_lp);
  localparam int mem_words_lp = 32;
  localparam int mem_index_width_lp = $clog2(mem_words_lp);

  typedef enum logic [1:0] {
    e_rd  = 2'd0,
    e_wr  = 2'd1,
    e_ack = 2'd2
  } msg_type_e;

  // sizes are log2 of the byte count
  typedef enum logic [2:0] {
    e_size_8  = 3'd3,
    e_size_16 = 3'd4,
    e_size_32 = 3'd5
  } size_e;

  // types with one input beat per word, so writes stream N:N
  localparam logic [3:0] mem_stream_mask_lp = 4'b0001 << e_wr;
  // types with one consumer operation per word
  localparam logic [3:0] fsm_stream_mask_lp = (4'b0001 << e_rd) | (4'b0001 << e_wr);

  typedef struct packed {
    msg_type_e                msg_type;
    size_e                    size;
    logic [addr_width_lp-1:0] addr;
  } msg_header_s;

  typedef struct packed {
    logic                     last;
    msg_header_s              header;
    logic [data_width_lp-1:0] data;
  } stream_beat_s;

  // word count minus one for a message size, also the wrap mask
  function automatic logic [cnt_width_lp-1:0] word_mask(size_e size);
    logic [addr_width_lp-1:0] size_bytes;
    logic [addr_width_lp-1:0] size_words;
    size_bytes = '0;
    size_bytes[size] = 1'b1;
    size_words = size_bytes >> word_offset_width_lp;
    return size_words[cnt_width_lp-1:0] - 1'b1;
  endfunction

endpackage

`default_nettype wire

// ==== stream_pump_in.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// inbound stream pump: buffers message beats and hands the
// consumer one operation per word in wrap-around order
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module stream_pump_in
  ( input  logic                                   clk_i
  , input  logic                                   reset_i
  // inbound stream
  , input  stream_pkg::msg_header_s                in_header_i
  , input  logic [stream_pkg::data_width_lp-1:0]   in_data_i
  , input  logic                                   in_v_i
  , input  logic                                   in_last_i
  , output logic                                   in_ready_and_o
  // consumer side
  , output stream_pkg::msg_header_s                fsm_header_o
  , output logic [stream_pkg::addr_width_lp-1:0]   fsm_addr_o
  , output logic [stream_pkg::data_width_lp-1:0]   fsm_data_o
  , output logic                                   fsm_v_o
  , input  logic                                   fsm_yumi_i
  , output logic                                   fsm_new_o
  , output logic                                   fsm_done_o
  );

  stream_pkg::stream_beat_s in_beat, beat_lo;
  logic beat_v_lo, beat_yumi_li;

  logic [stream_pkg::cnt_width_lp-1:0] num_stream, first_cnt, last_cnt;
  logic [stream_pkg::cnt_width_lp-1:0] current_cnt_r, stream_cnt, addr_cnt, wrap_cnt;
  logic [stream_pkg::block_offset_width_lp-1:0] critical_addr_r, critical_addr;
  logic streaming_r, cnt_up, is_last_cnt;
  logic is_fsm_stream, is_mem_stream, any_stream_new;

  assign in_beat.last   = in_last_i;
  assign in_beat.header = in_header_i;
  assign in_beat.data   = in_data_i;

  stream_two_fifo u_fifo
    ( .clk_i   (clk_i)
    , .reset_i (reset_i)
    , .data_i  (in_beat)
    , .v_i     (in_v_i)
    , .ready_o (in_ready_and_o)
    , .data_o  (beat_lo)
    , .v_o     (beat_v_lo)
    , .yumi_i  (beat_yumi_li)
    );

  always_comb
  begin
    num_stream = stream_pkg::word_mask(beat_lo.header.size);
    // the critical word is taken live from the head until a message starts streaming
    critical_addr = streaming_r
      ? critical_addr_r
      : beat_lo.header.addr[stream_pkg::block_offset_width_lp-1:0];
    first_cnt = critical_addr[stream_pkg::word_offset_width_lp+:stream_pkg::cnt_width_lp];
    last_cnt  = first_cnt + num_stream;

    // a single-word message never streams, whatever its type
    is_fsm_stream = stream_pkg::fsm_stream_mask_lp[beat_lo.header.msg_type]
                    & (first_cnt != last_cnt);
    is_mem_stream = stream_pkg::mem_stream_mask_lp[beat_lo.header.msg_type]
                    & (first_cnt != last_cnt);
    any_stream_new = (is_fsm_stream | is_mem_stream) & ~streaming_r;

    stream_cnt  = any_stream_new ? first_cnt : current_cnt_r;
    is_last_cnt = (stream_cnt == last_cnt) | (~is_fsm_stream & ~is_mem_stream);

    // bits under the size mask follow the counter, the rest keep the address bits
    addr_cnt = beat_lo.header.addr[stream_pkg::word_offset_width_lp+:stream_pkg::cnt_width_lp];
    wrap_cnt = (num_stream & stream_cnt) | (~num_stream & addr_cnt);
  end

  assign fsm_addr_o =
    { beat_lo.header.addr[stream_pkg::addr_width_lp-1:stream_pkg::block_offset_width_lp]
    , wrap_cnt
    , beat_lo.header.addr[stream_pkg::word_offset_width_lp-1:0]
    };

  always_comb
  begin
    fsm_header_o = beat_lo.header;
    // the header keeps pointing at the critical word for the whole message
    fsm_header_o.addr[stream_pkg::block_offset_width_lp-1:0] = critical_addr;
    fsm_data_o = beat_lo.data;
    fsm_v_o = beat_v_lo;

    if (is_fsm_stream & ~is_mem_stream)
    begin
      // 1:N, the single read beat is replayed and popped with the final word
      beat_yumi_li = is_last_cnt & beat_lo.last & fsm_yumi_i;
    end
    else
    begin
      // N:N and single-word messages pop a beat per operation
      beat_yumi_li = fsm_yumi_i;
    end

    cnt_up     = fsm_yumi_i & ~is_last_cnt;
    fsm_new_o  = ~streaming_r & fsm_v_o;
    fsm_done_o = is_last_cnt & fsm_yumi_i;
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      streaming_r   <= 1'b0;
      current_cnt_r <= '0;
    end
    else if (fsm_done_o)
    begin
      streaming_r   <= 1'b0;
      current_cnt_r <= '0;
    end
    else if (any_stream_new & cnt_up)
    begin
      // first word of a streamed message loads the counter past the critical word
      streaming_r   <= 1'b1;
      current_cnt_r <= first_cnt + 1'b1;
    end
    else if (cnt_up)
    begin
      current_cnt_r <= current_cnt_r + 1'b1;
    end
  end

  // held once streaming so later write beats cannot move the critical word
  always_ff @(posedge clk_i)
  begin
    if (~streaming_r)
      critical_addr_r <= beat_lo.header.addr[stream_pkg::block_offset_width_lp-1:0];
  end

endmodule

`default_nettype wire

// ==== stream_two_fifo.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// two entry beat buffer, valid/ready in and valid/yumi out
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module stream_two_fifo
  ( input  logic                   clk_i
  , input  logic                   reset_i
  , input  stream_pkg::stream_beat_s data_i
  , input  logic                   v_i
  , output logic                   ready_o
  , output stream_pkg::stream_beat_s data_o
  , output logic                   v_o
  , input  logic                   yumi_i
  );

  stream_pkg::stream_beat_s mem_r [2];
  logic wptr_r, rptr_r, full_r, empty_r;
  logic enq, deq;

  // a full buffer still takes a beat when the head leaves in the same cycle
  assign ready_o = ~full_r | yumi_i;
  assign enq = v_i & ready_o;
  assign deq = yumi_i;

  assign v_o = ~empty_r;
  assign data_o = mem_r[rptr_r];

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      wptr_r  <= 1'b0;
      rptr_r  <= 1'b0;
      full_r  <= 1'b0;
      empty_r <= 1'b1;
    end
    else
    begin
      if (enq)
        wptr_r <= ~wptr_r;
      if (deq)
        rptr_r <= ~rptr_r;
      // occupancy only moves when exactly one side fires
      if (enq & ~deq)
      begin
        empty_r <= 1'b0;
        full_r  <= ~empty_r;
      end
      else if (deq & ~enq)
      begin
        full_r  <= 1'b0;
        empty_r <= ~full_r;
      end
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (enq)
      mem_r[wptr_r] <= data_i;
  end

endmodule

`default_nettype wire
